/* axil_subsys_top.f */
rtl/axil_pkg.sv
rtl/axil_map_pkg.sv
rtl/axil_decoder.sv
rtl/axil_regfile.sv
rtl/axil_terminator.sv
rtl/axil_subsys_top.sv
bench/tb_axil_subsys.sv

/* Makefile */
# Verilator build and run of the AXI4-Lite subsystem testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_axil_subsys
FILELIST  := axil_subsys_top.f
LOG       := sim.log
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fails unless the log holds the pass message"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* bench/tb_axil_subsys.sv */
// Testbench for the AXI4-Lite register subsystem
// The stimulus table runs twice with a reset in between, first with bready and rready
// held high, then with LFSR back-pressure on both
// Tasks are called on a falling edge and return on one
`timescale 1ns/1ps

module tb_axil_subsys;

    typedef struct packed {
        logic                            is_write;
        logic [axil_pkg::addr_width-1:0] addr;
        logic [axil_pkg::data_width-1:0] data;
        logic [axil_pkg::strb_width-1:0] strb;
        logic [axil_pkg::data_width-1:0] exp_data;
        axil_pkg::resp_e                 exp_resp;
    } row_t;

    localparam int              timeout_cycles = 200;
    localparam logic            wr = 1'b1;
    localparam logic            rd = 1'b0;
    localparam axil_pkg::resp_e okay = axil_pkg::resp_okay;
    localparam axil_pkg::resp_e decerr = axil_pkg::resp_decerr;

    logic                            s_axi4l_aclk;
    logic                            rst_n;
    logic [axil_pkg::addr_width-1:0] awaddr;
    logic [2:0]                      awprot;
    logic                            awvalid;
    logic                            awready;
    logic [axil_pkg::data_width-1:0] wdata;
    logic [axil_pkg::strb_width-1:0] wstrb;
    logic                            wvalid;
    logic                            wready;
    logic [1:0]                      bresp;
    logic                            bvalid;
    logic                            bready;
    logic [axil_pkg::addr_width-1:0] araddr;
    logic [2:0]                      arprot;
    logic                            arvalid;
    logic                            arready;
    logic [axil_pkg::data_width-1:0] rdata;
    logic [1:0]                      rresp;
    logic                            rvalid;
    logic                            rready;

    row_t        table_q[$];
    logic [31:0] lfsr;
    logic        back_pressure;
    logic        timed_out;
    int          errors;
    int          tests;

    // Handshakes at the last rising edge, read back on the falling edge
    logic                            wr_fire;
    logic                            b_fire;
    logic                            ar_fire;
    logic                            r_fire;
    logic [1:0]                      b_resp_seen;
    logic [axil_pkg::data_width-1:0] r_data_seen;
    logic [1:0]                      r_resp_seen;

    axil_subsys_top uut (.*);

    initial begin
        s_axi4l_aclk = 1'b0;
        forever #4 s_axi4l_aclk = ~s_axi4l_aclk;
    end

    always @(posedge s_axi4l_aclk) begin
        wr_fire     <= awvalid && awready && wvalid && wready;  // AW and W go as a pair
        b_fire      <= bvalid && bready;
        b_resp_seen <= bresp;
        ar_fire     <= arvalid && arready;
        r_fire      <= rvalid && rready;
        r_data_seen <= rdata;
        r_resp_seen <= rresp;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic random_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    function automatic logic ready_level();
        return back_pressure ? random_bit() : 1'b1;
    endfunction

    task automatic add_row(input logic is_write,
                           input logic [31:0] addr,
                           input logic [31:0] data,
                           input logic [3:0] strb,
                           input logic [31:0] exp_data,
                           input axil_pkg::resp_e exp_resp);
        row_t row;
        row.is_write = is_write;
        row.addr     = addr;
        row.data     = data;
        row.strb     = strb;
        row.exp_data = exp_data;
        row.exp_resp = exp_resp;
        table_q.push_back(row);
    endtask

    task automatic build_table();
        for (int i = 0; i < 4; i++) add_row(rd, 32'h0000_0000 + 4 * i, '0, '0, '0, okay);
        for (int i = 0; i < 8; i++) add_row(rd, 32'h0000_0100 + 4 * i, '0, '0, '0, okay);
        // Full words in every control register
        add_row(wr, 32'h0000_0000, 32'h0123_4567, 4'hF, '0, okay);
        add_row(wr, 32'h0000_0004, 32'h89AB_CDEF, 4'hF, '0, okay);
        add_row(wr, 32'h0000_0008, 32'hFFFF_0000, 4'hF, '0, okay);
        add_row(wr, 32'h0000_000C, 32'hA5A5_5A5A, 4'hF, '0, okay);
        add_row(rd, 32'h0000_0000, '0, '0, 32'h0123_4567, okay);
        add_row(rd, 32'h0000_0004, '0, '0, 32'h89AB_CDEF, okay);
        add_row(rd, 32'h0000_0008, '0, '0, 32'hFFFF_0000, okay);
        add_row(rd, 32'h0000_000C, '0, '0, 32'hA5A5_5A5A, okay);
        // Bytes 0 and 2 replaced, 1 and 3 kept
        add_row(wr, 32'h0000_0108, 32'h1122_3344, 4'hF, '0, okay);
        add_row(wr, 32'h0000_0108, 32'hAABB_CCDD, 4'b0101, '0, okay);
        add_row(rd, 32'h0000_0108, '0, '0, 32'h11BB_33DD, okay);
        add_row(wr, 32'h0000_0000, 32'h0000_00C0, 4'hF, '0, okay);
        add_row(wr, 32'h0000_0100, 32'h0000_05A0, 4'hF, '0, okay);
        add_row(rd, 32'h0000_0000, '0, '0, 32'h0000_00C0, okay);
        add_row(rd, 32'h0000_0100, '0, '0, 32'h0000_05A0, okay);
        // Just past each window, then far away
        add_row(wr, 32'h0000_0010, 32'hBAD0_0010, 4'hF, '0, decerr);
        add_row(rd, 32'h0000_0010, '0, '0, 32'hDEAD_BEEF, decerr);
        add_row(wr, 32'h0000_0120, 32'hBAD0_0120, 4'hF, '0, decerr);
        add_row(rd, 32'h0000_0120, '0, '0, 32'hDEAD_BEEF, decerr);
        add_row(wr, 32'h8000_0000, 32'hBAD8_0000, 4'hF, '0, decerr);
        add_row(rd, 32'h8000_0000, '0, '0, 32'hDEAD_BEEF, decerr);
        add_row(rd, 32'h0000_0000, '0, '0, 32'h0000_00C0, okay);
        add_row(rd, 32'h0000_000C, '0, '0, 32'hA5A5_5A5A, okay);
        add_row(rd, 32'h0000_0100, '0, '0, 32'h0000_05A0, okay);
        add_row(rd, 32'h0000_011C, '0, '0, 32'h0000_0000, okay);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) @(negedge s_axi4l_aclk);
        rst_n = 1'b1;
    endtask

    task automatic do_write(input row_t row, output logic [1:0] resp);
        int n;
        resp    = '0;
        awaddr  = row.addr;
        wdata   = row.data;
        wstrb   = row.strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge s_axi4l_aclk);
            n++;
        end while (!wr_fire && n < timeout_cycles);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!wr_fire) begin
            $display("timeout waiting for awready and wready at %0t", $time);
            timed_out = 1'b1;
            return;
        end
        n = 0;
        bready = ready_level();
        do begin
            @(negedge s_axi4l_aclk);
            n++;
            if (!b_fire) bready = ready_level();
        end while (!b_fire && n < timeout_cycles);
        bready = 1'b0;
        if (!b_fire) begin
            $display("timeout waiting for bvalid at %0t", $time);
            timed_out = 1'b1;
            return;
        end
        resp = b_resp_seen;
    endtask

    task automatic do_read(input row_t row, output logic [31:0] data, output logic [1:0] resp);
        int n;
        data    = '0;
        resp    = '0;
        araddr  = row.addr;
        arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge s_axi4l_aclk);
            n++;
        end while (!ar_fire && n < timeout_cycles);
        arvalid = 1'b0;
        if (!ar_fire) begin
            $display("timeout waiting for arready at %0t", $time);
            timed_out = 1'b1;
            return;
        end
        n = 0;
        rready = ready_level();
        do begin
            @(negedge s_axi4l_aclk);
            n++;
            if (!r_fire) rready = ready_level();
        end while (!r_fire && n < timeout_cycles);
        rready = 1'b0;
        if (!r_fire) begin
            $display("timeout waiting for rvalid at %0t", $time);
            timed_out = 1'b1;
            return;
        end
        data = r_data_seen;
        resp = r_resp_seen;
    endtask

    task automatic run_row(input row_t row);
        logic [1:0]  resp;
        logic [31:0] data;
        int          errors_at_start;
        errors_at_start = errors;
        data            = '0;
        if (row.is_write) do_write(row, resp);
        else do_read(row, data, resp);
        tests++;
        if (timed_out) begin
            $display("test %0d: 0x%08h did not complete", tests, row.addr);
            return;
        end
        assert (resp == row.exp_resp) else begin
            $display("MISMATCH at %0t: resp %0d at 0x%08h, expected %0d",
                     $time, resp, row.addr, row.exp_resp);
            errors++;
        end
        if (!row.is_write) begin
            assert (data == row.exp_data) else begin
                $display("MISMATCH at %0t: rdata 0x%08h at 0x%08h, expected 0x%08h",
                         $time, data, row.addr, row.exp_data);
                errors++;
            end
        end
        $display("test %0d: %s 0x%08h %s", tests, row.is_write ? "write" : "read",
                 row.addr, (errors == errors_at_start) ? "ok" : "bad");
    endtask

    initial begin
        rst_n         = 1'b0;
        awaddr        = '0;
        awprot        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arprot        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        lfsr          = 32'h1618;
        back_pressure = 1'b0;
        timed_out     = 1'b0;
        errors        = 0;
        tests         = 0;
        build_table();
        for (int pass = 0; pass < 2 && !timed_out; pass++) begin
            back_pressure = (pass == 1);   // Second pass throttles bready and rready
            apply_reset();
            for (int i = 0; i < table_q.size() && !timed_out; i++) begin
                run_row(table_q[i]);
            end
        end
        $display("tests %0d, errors %0d, timeout %0d", tests, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* rtl/axil_subsys_top.sv */
// AXI4-Lite register subsystem: control file, status file and a terminator
// One transaction in flight at a time; prot inputs are ignored
`timescale 1ns/1ps

module axil_subsys_top (
    input  logic                            s_axi4l_aclk,
    input  logic                            rst_n,
    input  logic [axil_pkg::addr_width-1:0] awaddr,
    input  logic [2:0]                      awprot,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [axil_pkg::data_width-1:0] wdata,
    input  logic [axil_pkg::strb_width-1:0] wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [axil_pkg::addr_width-1:0] araddr,
    input  logic [2:0]                      arprot,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [axil_pkg::data_width-1:0] rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready
);

    logic [axil_map_pkg::num_targets-1:0]                           t_awvalid;
    logic [axil_map_pkg::num_targets-1:0][axil_pkg::addr_width-1:0] t_awaddr;
    logic [axil_map_pkg::num_targets-1:0]                           t_wvalid;
    logic [axil_map_pkg::num_targets-1:0][axil_pkg::data_width-1:0] t_wdata;
    logic [axil_map_pkg::num_targets-1:0][axil_pkg::strb_width-1:0] t_wstrb;
    logic [axil_map_pkg::num_targets-1:0]                           t_bready;
    logic [axil_map_pkg::num_targets-1:0]                           t_arvalid;
    logic [axil_map_pkg::num_targets-1:0][axil_pkg::addr_width-1:0] t_araddr;
    logic [axil_map_pkg::num_targets-1:0]                           t_rready;
    logic [axil_map_pkg::num_targets-1:0]                           t_awready;
    logic [axil_map_pkg::num_targets-1:0]                           t_wready;
    logic [axil_map_pkg::num_targets-1:0]                           t_bvalid;
    logic [axil_map_pkg::num_targets-1:0][1:0]                      t_bresp;
    logic [axil_map_pkg::num_targets-1:0]                           t_arready;
    logic [axil_map_pkg::num_targets-1:0]                           t_rvalid;
    logic [axil_map_pkg::num_targets-1:0][axil_pkg::data_width-1:0] t_rdata;
    logic [axil_map_pkg::num_targets-1:0][1:0]                      t_rresp;

    axil_decoder u_dec (.*);

    axil_regfile #(
        .num_regs (axil_map_pkg::ctrl_regs)
    ) u_ctrl (
        .s_axi4l_aclk (s_axi4l_aclk),
        .rst_n        (rst_n),
        .awaddr       (t_awaddr[axil_map_pkg::tgt_ctrl]),
        .awvalid      (t_awvalid[axil_map_pkg::tgt_ctrl]),
        .awready      (t_awready[axil_map_pkg::tgt_ctrl]),
        .wdata        (t_wdata[axil_map_pkg::tgt_ctrl]),
        .wstrb        (t_wstrb[axil_map_pkg::tgt_ctrl]),
        .wvalid       (t_wvalid[axil_map_pkg::tgt_ctrl]),
        .wready       (t_wready[axil_map_pkg::tgt_ctrl]),
        .bresp        (t_bresp[axil_map_pkg::tgt_ctrl]),
        .bvalid       (t_bvalid[axil_map_pkg::tgt_ctrl]),
        .bready       (t_bready[axil_map_pkg::tgt_ctrl]),
        .araddr       (t_araddr[axil_map_pkg::tgt_ctrl]),
        .arvalid      (t_arvalid[axil_map_pkg::tgt_ctrl]),
        .arready      (t_arready[axil_map_pkg::tgt_ctrl]),
        .rdata        (t_rdata[axil_map_pkg::tgt_ctrl]),
        .rresp        (t_rresp[axil_map_pkg::tgt_ctrl]),
        .rvalid       (t_rvalid[axil_map_pkg::tgt_ctrl]),
        .rready       (t_rready[axil_map_pkg::tgt_ctrl])
    );

    axil_regfile #(
        .num_regs (axil_map_pkg::stat_regs)
    ) u_stat (
        .s_axi4l_aclk (s_axi4l_aclk),
        .rst_n        (rst_n),
        .awaddr       (t_awaddr[axil_map_pkg::tgt_stat]),
        .awvalid      (t_awvalid[axil_map_pkg::tgt_stat]),
        .awready      (t_awready[axil_map_pkg::tgt_stat]),
        .wdata        (t_wdata[axil_map_pkg::tgt_stat]),
        .wstrb        (t_wstrb[axil_map_pkg::tgt_stat]),
        .wvalid       (t_wvalid[axil_map_pkg::tgt_stat]),
        .wready       (t_wready[axil_map_pkg::tgt_stat]),
        .bresp        (t_bresp[axil_map_pkg::tgt_stat]),
        .bvalid       (t_bvalid[axil_map_pkg::tgt_stat]),
        .bready       (t_bready[axil_map_pkg::tgt_stat]),
        .araddr       (t_araddr[axil_map_pkg::tgt_stat]),
        .arvalid      (t_arvalid[axil_map_pkg::tgt_stat]),
        .arready      (t_arready[axil_map_pkg::tgt_stat]),
        .rdata        (t_rdata[axil_map_pkg::tgt_stat]),
        .rresp        (t_rresp[axil_map_pkg::tgt_stat]),
        .rvalid       (t_rvalid[axil_map_pkg::tgt_stat]),
        .rready       (t_rready[axil_map_pkg::tgt_stat])
    );

    // Write data never reaches the terminator
    axil_terminator #(
        .read_value (32'hDEAD_BEEF),
        .resp       (axil_pkg::resp_decerr)
    ) u_term (
        .s_axi4l_aclk (s_axi4l_aclk),
        .rst_n        (rst_n),
        .awaddr       (t_awaddr[axil_map_pkg::tgt_term]),
        .awvalid      (t_awvalid[axil_map_pkg::tgt_term]),
        .awready      (t_awready[axil_map_pkg::tgt_term]),
        .wvalid       (t_wvalid[axil_map_pkg::tgt_term]),
        .wready       (t_wready[axil_map_pkg::tgt_term]),
        .bresp        (t_bresp[axil_map_pkg::tgt_term]),
        .bvalid       (t_bvalid[axil_map_pkg::tgt_term]),
        .bready       (t_bready[axil_map_pkg::tgt_term]),
        .araddr       (t_araddr[axil_map_pkg::tgt_term]),
        .arvalid      (t_arvalid[axil_map_pkg::tgt_term]),
        .arready      (t_arready[axil_map_pkg::tgt_term]),
        .rdata        (t_rdata[axil_map_pkg::tgt_term]),
        .rresp        (t_rresp[axil_map_pkg::tgt_term]),
        .rvalid       (t_rvalid[axil_map_pkg::tgt_term]),
        .rready       (t_rready[axil_map_pkg::tgt_term])
    );

endmodule

/* rtl/axil_terminator.sv */
// Catch-all target for unmapped addresses
// Writes are dropped; reads return read_value; both answer with resp
`timescale 1ns/1ps

module axil_terminator #(
    parameter logic [axil_pkg::data_width-1:0] read_value = '0,
    parameter axil_pkg::resp_e                 resp       = axil_pkg::resp_decerr
) (
    input  logic                            s_axi4l_aclk,
    input  logic                            rst_n,
    input  logic [axil_pkg::addr_width-1:0] awaddr,     // Not decoded here
    input  logic                            awvalid,
    output logic                            awready,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [axil_pkg::addr_width-1:0] araddr,     // Not decoded here
    input  logic                            arvalid,
    output logic                            arready,
    output logic [axil_pkg::data_width-1:0] rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready
);

    assign awready = (!bvalid || bready) && wvalid;
    assign wready  = (!bvalid || bready) && awvalid;
    assign arready = !rvalid || rready;
    assign bresp   = resp;
    assign rresp   = resp;
    assign rdata   = read_value;

    always_ff @(posedge s_axi4l_aclk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (bready) bvalid <= 1'b0;
            if (awvalid && awready) bvalid <= 1'b1;     // Wins over a same-cycle drain
            if (rready) rvalid <= 1'b0;
            if (arvalid && arready) rvalid <= 1'b1;
        end
    end

    // A held read response blocks any new read request
    a_one_read_in_flight: assert property (@(posedge s_axi4l_aclk) disable iff (!rst_n)
        rvalid && !rready |-> !arvalid);

endmodule

/* rtl/axil_regfile.sv */
// Word register file addressed by the offset into its window
// Every access answers OKAY; offsets past num_regs are the decoder's job to prevent
// Contents clear on reset
`timescale 1ns/1ps

module axil_regfile #(
    parameter int num_regs = 4
) (
    input  logic                            s_axi4l_aclk,
    input  logic                            rst_n,
    input  logic [axil_pkg::addr_width-1:0] awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [axil_pkg::data_width-1:0] wdata,
    input  logic [axil_pkg::strb_width-1:0] wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [axil_pkg::addr_width-1:0] araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [axil_pkg::data_width-1:0] rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready
);

    localparam int idx_width = (num_regs > 1) ? $clog2(num_regs) : 1;

    logic [axil_pkg::data_width-1:0] regs [num_regs];
    logic [idx_width-1:0]            wr_idx;
    logic [idx_width-1:0]            rd_idx;
    logic                            wr_fire;
    logic                            rd_fire;

    assign wr_idx  = awaddr[idx_width+1:2];
    assign rd_idx  = araddr[idx_width+1:2];

    // AW and W are only taken as a pair
    assign awready = (!bvalid || bready) && wvalid;
    assign wready  = (!bvalid || bready) && awvalid;
    assign arready = !rvalid || rready;
    assign wr_fire = awvalid && awready;
    assign rd_fire = arvalid && arready;
    assign bresp   = axil_pkg::resp_okay;
    assign rresp   = axil_pkg::resp_okay;

    always_ff @(posedge s_axi4l_aclk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (bready) bvalid <= 1'b0;
            if (rready) rvalid <= 1'b0;
            if (wr_fire) begin
                bvalid <= 1'b1;
                for (int b = 0; b < axil_pkg::strb_width; b++) begin
                    if (wstrb[b]) regs[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            if (rd_fire) rvalid <= 1'b1;
        end
    end

    always_ff @(posedge s_axi4l_aclk) begin
        if (rd_fire) rdata <= regs[rd_idx];     // Held until the next accepted read
    end

    // The decoder only forwards offsets inside this window
    a_wr_index: assert property (@(posedge s_axi4l_aclk) disable iff (!rst_n)
        wr_fire |-> awaddr < 4 * num_regs);

    a_rd_index: assert property (@(posedge s_axi4l_aclk) disable iff (!rst_n)
        rd_fire |-> araddr < 4 * num_regs);

endmodule

/* rtl/axil_decoder.sv */
// Routes one AXI4-Lite transaction at a time to the target its address selects
// A write needs AW and W valid together and wins over a read in the same cycle
// Targets see the word-aligned offset into their window; prot bits are ignored
`timescale 1ns/1ps

module axil_decoder (
    input  logic                                                      s_axi4l_aclk,
    input  logic                                                      rst_n,
    input  logic [axil_pkg::addr_width-1:0]                           awaddr,
    input  logic [2:0]                                                awprot,
    input  logic                                                      awvalid,
    output logic                                                      awready,
    input  logic [axil_pkg::data_width-1:0]                           wdata,
    input  logic [axil_pkg::strb_width-1:0]                           wstrb,
    input  logic                                                      wvalid,
    output logic                                                      wready,
    output logic [1:0]                                                bresp,
    output logic                                                      bvalid,
    input  logic                                                      bready,
    input  logic [axil_pkg::addr_width-1:0]                           araddr,
    input  logic [2:0]                                                arprot,
    input  logic                                                      arvalid,
    output logic                                                      arready,
    output logic [axil_pkg::data_width-1:0]                           rdata,
    output logic [1:0]                                                rresp,
    output logic                                                      rvalid,
    input  logic                                                      rready,
    // Target side, indexed by target_e
    output logic [axil_map_pkg::num_targets-1:0]                      t_awvalid,
    output logic [axil_map_pkg::num_targets-1:0][axil_pkg::addr_width-1:0] t_awaddr,
    output logic [axil_map_pkg::num_targets-1:0]                      t_wvalid,
    output logic [axil_map_pkg::num_targets-1:0][axil_pkg::data_width-1:0] t_wdata,
    output logic [axil_map_pkg::num_targets-1:0][axil_pkg::strb_width-1:0] t_wstrb,
    output logic [axil_map_pkg::num_targets-1:0]                      t_bready,
    output logic [axil_map_pkg::num_targets-1:0]                      t_arvalid,
    output logic [axil_map_pkg::num_targets-1:0][axil_pkg::addr_width-1:0] t_araddr,
    output logic [axil_map_pkg::num_targets-1:0]                      t_rready,
    input  logic [axil_map_pkg::num_targets-1:0]                      t_awready,
    input  logic [axil_map_pkg::num_targets-1:0]                      t_wready,
    input  logic [axil_map_pkg::num_targets-1:0]                      t_bvalid,
    input  logic [axil_map_pkg::num_targets-1:0][1:0]                 t_bresp,
    input  logic [axil_map_pkg::num_targets-1:0]                      t_arready,
    input  logic [axil_map_pkg::num_targets-1:0]                      t_rvalid,
    input  logic [axil_map_pkg::num_targets-1:0][axil_pkg::data_width-1:0] t_rdata,
    input  logic [axil_map_pkg::num_targets-1:0][1:0]                 t_rresp
);

    axil_pkg::dec_state_e              state;
    axil_map_pkg::target_e             req_tgt;
    logic [axil_pkg::addr_width-1:0]   req_off;
    logic [axil_pkg::data_width-1:0]   req_data;
    logic [axil_pkg::strb_width-1:0]   req_strb;

    logic                              write_req;
    logic [axil_pkg::addr_width-1:0]   sel_addr;
    logic [axil_pkg::addr_width-1:0]   sel_base;
    axil_map_pkg::target_e             sel_tgt;

    function automatic logic in_window(input logic [axil_pkg::addr_width-1:0] a,
                                       input logic [axil_pkg::addr_width-1:0] base,
                                       input int regs);
        return (a >= base) && ((a - base) < 4 * regs);
    endfunction

    // Decode whichever request would be taken this cycle
    always_comb begin
        write_req     = awvalid && wvalid;
        sel_addr      = write_req ? awaddr : araddr;
        sel_addr[1:0] = 2'b00;                      // Byte lane bits ignored
        if (in_window(sel_addr, axil_map_pkg::ctrl_base, axil_map_pkg::ctrl_regs)) begin
            sel_tgt  = axil_map_pkg::tgt_ctrl;
            sel_base = axil_map_pkg::ctrl_base;
        end else if (in_window(sel_addr, axil_map_pkg::stat_base, axil_map_pkg::stat_regs)) begin
            sel_tgt  = axil_map_pkg::tgt_stat;
            sel_base = axil_map_pkg::stat_base;
        end else begin
            sel_tgt  = axil_map_pkg::tgt_term;
            sel_base = '0;                          // Terminator sees the raw address
        end
    end

    always_ff @(posedge s_axi4l_aclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= axil_pkg::st_idle;
            req_tgt <= axil_map_pkg::tgt_term;
        end else begin
            case (state)
                axil_pkg::st_idle: begin
                    req_tgt <= sel_tgt;
                    if (write_req) begin
                        state <= axil_pkg::st_write;
                    end else if (arvalid) begin
                        state <= axil_pkg::st_read;
                    end
                end
                // Targets take AW and W in the same cycle
                axil_pkg::st_write: if (t_awready[req_tgt] && t_wready[req_tgt]) begin
                    state <= axil_pkg::st_bresp;
                end
                axil_pkg::st_read: if (t_arready[req_tgt]) state <= axil_pkg::st_rresp;
                axil_pkg::st_bresp: if (bvalid && bready) state <= axil_pkg::st_idle;
                axil_pkg::st_rresp: if (rvalid && rready) state <= axil_pkg::st_idle;
                default: state <= axil_pkg::st_idle;
            endcase
        end
    end

    // Payload follows the bus while idle and freezes once a request is taken
    always_ff @(posedge s_axi4l_aclk) begin
        if (state == axil_pkg::st_idle) begin
            req_off  <= sel_addr - sel_base;
            req_data <= wdata;
            req_strb <= wstrb;
        end
    end

    assign awready = (state == axil_pkg::st_idle) && write_req;
    assign wready  = (state == axil_pkg::st_idle) && write_req;
    assign arready = (state == axil_pkg::st_idle) && !write_req;

    assign t_awaddr = {axil_map_pkg::num_targets{req_off}};
    assign t_araddr = {axil_map_pkg::num_targets{req_off}};
    assign t_wdata  = {axil_map_pkg::num_targets{req_data}};
    assign t_wstrb  = {axil_map_pkg::num_targets{req_strb}};

    always_comb begin
        t_awvalid          = '0;
        t_wvalid           = '0;
        t_arvalid          = '0;
        t_bready           = '0;
        t_rready           = '0;
        t_awvalid[req_tgt] = (state == axil_pkg::st_write);
        t_wvalid[req_tgt]  = (state == axil_pkg::st_write);
        t_arvalid[req_tgt] = (state == axil_pkg::st_read);
        t_bready[req_tgt]  = (state == axil_pkg::st_bresp) && bready;
        t_rready[req_tgt]  = (state == axil_pkg::st_rresp) && rready;
    end

    // Responses pass through unchanged
    assign bvalid = (state == axil_pkg::st_bresp) && t_bvalid[req_tgt];
    assign bresp  = t_bresp[req_tgt];
    assign rvalid = (state == axil_pkg::st_rresp) && t_rvalid[req_tgt];
    assign rdata  = t_rdata[req_tgt];
    assign rresp  = t_rresp[req_tgt];

    // At most one target holds a response at any time
    a_one_target: assert property (@(posedge s_axi4l_aclk) disable iff (!rst_n)
        $onehot0(t_bvalid | t_rvalid));

    a_bvalid_hold: assert property (@(posedge s_axi4l_aclk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid);

endmodule

/* rtl/axil_map_pkg.sv */
// Address map of the subsystem
// Windows are word aligned and must not overlap; anything outside them goes to the terminator
// Target numbers index the per-target channel arrays

package axil_map_pkg;

    typedef enum logic [1:0] {
        tgt_ctrl = 2'd0,
        tgt_stat = 2'd1,
        tgt_term = 2'd2
    } target_e;

    localparam int num_targets = 3;

    localparam logic [axil_pkg::addr_width-1:0] ctrl_base = 32'h0000_0000;
    localparam int                              ctrl_regs = 4;

    localparam logic [axil_pkg::addr_width-1:0] stat_base = 32'h0000_0100;
    localparam int                              stat_regs = 8;

endpackage

/* rtl/axil_pkg.sv */
// AXI4-Lite bus definitions shared by the decoder, the targets and the testbench
// Data path is fixed at 32 bits, one strobe bit per byte

package axil_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // Encoding follows the AXI specification
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_e;

    typedef enum logic [2:0] {
        st_idle,
        st_write,
        st_read,
        st_bresp,
        st_rresp
    } dec_state_e;

endpackage
